// File: gpioTop.f
verilog/gpioCfgPkg.sv
verilog/apbMapPkg.sv
verilog/gpioRegBlock.sv
verilog/gpioIrqUnit.sv
verilog/gpioTop.sv
bench/gpioTop_props.sv
bench/gpioTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the GPIO testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir

verilator --binary --timing --assert -f gpioTop.f --top-module gpioTb \
  -Mdir "$buildDir" -o gpioSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit "$status"
fi

# Keep running past the first assertion error so the testbench ends the run itself
"./$buildDir/gpioSim" +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi

echo "simulation finished with status 0"
exit 0

// File: bench/gpioTb.sv
`timescale 1ns/100ps

module gpioTb;
  import gpioCfgPkg::*;
  import apbMapPkg::*;

  // Transfers in the config readback, output, input, edge and level phases
  localparam int transferCount = 64 + 8 + 8 + 51 + 44;
  localparam int watchdogCycles = transferCount * 4 + 200;

  logic pclk = 1'b0;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  logic [addrWidth-1:0] paddr;
  logic [dataWidth-1:0] pwdata;
  logic [pinCount-1:0] gpioIn;
  logic [dataWidth-1:0] prdata;
  logic pready;
  logic pslverr;
  logic [pinCount-1:0] gpioOut;
  logic [pinCount-1:0] gpioOe;
  logic [pinCount-1:0] irq;
  logic irqOr;
  logic [15:0] lfsrState = 16'd41128;

  always #20 pclk = ~pclk;

  gpioTop i_dut (
    .pclk    (pclk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .gpioIn  (gpioIn),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .gpioOut (gpioOut),
    .gpioOe  (gpioOe),
    .irq     (irq),
    .irqOr   (irqOr)
  );

  bind gpioTop gpioTopProps i_props (
    .pclk    (pclk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .gpioIn  (gpioIn),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .gpioOut (gpioOut),
    .gpioOe  (gpioOe),
    .irq     (irq),
    .irqOr   (irqOr)
  );

  task automatic failRun(input string reason);
    $display(">>> FAIL");
    $fatal(1, "%s", reason);
  endtask

  // Galois LFSR with taps 16 14 13 11 stepped once per bit taken
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      bits = {bits[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
    end
    return bits;
  endfunction

  task automatic writeReg(input logic [addrWidth-1:0] addr, input logic [dataWidth-1:0] data);
    @(posedge pclk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b1;
    paddr <= addr;
    pwdata <= data;
    @(posedge pclk);
    penable <= 1'b1;
    @(posedge pclk);
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  task automatic readReg(input logic [addrWidth-1:0] addr);
    @(posedge pclk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= addr;
    @(posedge pclk);
    penable <= 1'b1;
    @(posedge pclk);
    psel <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic setPins(input logic [pinCount-1:0] pattern);
    @(posedge pclk);
    gpioIn <= pattern;
  endtask

  task automatic waitCycles(input int count);
    repeat (count) @(posedge pclk);
  endtask

  initial
  begin
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
    paddr <= '0;
    pwdata <= '0;
    gpioIn <= '0;
    reset <= 1'b1;
    waitCycles(8);
    reset <= 1'b0;
    for (int i = 0; i < pinCount; i++)
    begin
      writeReg(8'(i * 4), takeBits(dataWidth));
      readReg(8'(i * 4));
    end
    for (int round = 0; round < 4; round++)
    begin
      writeReg(outputAddr, takeBits(dataWidth));
      readReg(outputAddr);
      waitCycles(2);
    end
    for (int round = 0; round < 8; round++)
    begin
      setPins(takeBits(pinCount));
      waitCycles(3);
      readReg(inputAddr);
    end
    // Edge types spread over the pins with input and interrupt enabled on all
    for (int i = 0; i < pinCount; i++)
    begin
      writeReg(8'(i * 4), {24'h0, 3'(i % 3 + 2), 5'b01010});
    end
    writeReg(irqStatusAddr, '1);
    for (int round = 0; round < 6; round++)
    begin
      // The clear lands on the same edge that records the new pin edges
      setPins(takeBits(pinCount));
      writeReg(irqStatusAddr, takeBits(dataWidth));
      waitCycles(2);
      readReg(irqStatusAddr);
      readReg(inputAddr);
    end
    // Level high, level low, a disabled pin and an unknown code in turn
    for (int i = 0; i < pinCount; i++)
    begin
      case (i % 4)
        0: writeReg(8'(i * 4), {24'h0, irqLevelHigh, 5'b01010});
        1: writeReg(8'(i * 4), {24'h0, irqLevelLow, 5'b01010});
        2: writeReg(8'(i * 4), {24'h0, irqLevelHigh, 5'b00010});
        default: writeReg(8'(i * 4), {24'h0, 3'(5 + i % 3), 5'b01010});
      endcase
    end
    for (int round = 0; round < 6; round++)
    begin
      setPins(takeBits(pinCount));
      waitCycles(4);
      readReg(irqStatusAddr);
      readReg(inputAddr);
    end
    waitCycles(4);
    if (i_dut.i_props.failCount == 0)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
    begin
      failRun("assertion failures were reported during the run");
    end
  end

  initial
  begin
    wait (i_dut.i_props.failCount != 0);
    failRun("an assertion on the DUT failed");
  end

  initial
  begin
    repeat (watchdogCycles) @(posedge pclk);
    failRun("watchdog expired before the test sequence finished");
  end

endmodule

// File: bench/gpioTop_props.sv
`timescale 1ns/100ps

module gpioTopProps (
  input logic                              pclk,
  input logic                              reset,
  input logic                              psel,
  input logic                              penable,
  input logic                              pwrite,
  input logic [apbMapPkg::addrWidth-1:0]   paddr,
  input logic [apbMapPkg::dataWidth-1:0]   pwdata,
  input logic [gpioCfgPkg::pinCount-1:0]   gpioIn,
  input logic [apbMapPkg::dataWidth-1:0]   prdata,
  input logic                              pready,
  input logic                              pslverr,
  input logic [gpioCfgPkg::pinCount-1:0]   gpioOut,
  input logic [gpioCfgPkg::pinCount-1:0]   gpioOe,
  input logic [gpioCfgPkg::pinCount-1:0]   irq,
  input logic                              irqOr
);
  import gpioCfgPkg::*;
  import apbMapPkg::*;

  int failCount = 0;
  logic [7:0] cfgShadow [pinCount];
  logic [pinCount-1:0] outShadow;
  logic [pinCount-1:0] syncFirst;
  logic [pinCount-1:0] syncLevel;
  logic [pinCount-1:0] prevLevel;
  logic [pinCount-1:0] edgeSticky;
  logic [pinCount-1:0] edgeKind;
  logic [pinCount-1:0] edgeHit;
  logic [pinCount-1:0] levelHit;
  logic [pinCount-1:0] inMasked;
  logic [pinCount-1:0] expIrq;
  logic [pinCount-1:0] expOut;
  logic [pinCount-1:0] expOe;
  logic [pinCount-1:0] clearMask;
  logic [dataWidth-1:0] expRead;
  logic writeCycle;

  assign writeCycle = psel & penable & pwrite;
  assign clearMask = (writeCycle && paddr == irqStatusAddr) ? pwdata : '0;

  // Expected pin view built from the shadow configuration bytes
  always_comb
  begin
    for (int i = 0; i < pinCount; i++)
    begin
      edgeKind[i] = 1'b1;
      edgeHit[i] = 1'b0;
      levelHit[i] = 1'b0;
      inMasked[i] = syncLevel[i] & cfgShadow[i][1];
      case (cfgShadow[i][7:5])
        irqLevelHigh:
        begin
          edgeKind[i] = 1'b0;
          levelHit[i] = syncLevel[i];
        end
        irqLevelLow:
        begin
          edgeKind[i] = 1'b0;
          levelHit[i] = ~syncLevel[i];
        end
        irqRising:    edgeHit[i] = syncLevel[i] & ~prevLevel[i];
        irqFalling:   edgeHit[i] = ~syncLevel[i] & prevLevel[i];
        irqBothEdges: edgeHit[i] = syncLevel[i] ^ prevLevel[i];
        default:      edgeKind[i] = 1'b0;
      endcase
      expIrq[i] = cfgShadow[i][3] & (edgeKind[i] ? edgeSticky[i] : levelHit[i]);
    end
  end

  always_comb
  begin
    expRead = '0;
    if (paddr < cfgLimit)
    begin
      expRead = dataWidth'(cfgShadow[paddr[$clog2(pinCount)+1:2]]);
    end
    else if (paddr == irqStatusAddr)
    begin
      expRead = expIrq;
    end
    else if (paddr == inputAddr)
    begin
      expRead = inMasked;
    end
    else if (paddr == outputAddr)
    begin
      expRead = outShadow;
    end
  end

  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      for (int i = 0; i < pinCount; i++)
      begin
        cfgShadow[i] <= '0;
      end
      outShadow <= '0;
      syncFirst <= '0;
      syncLevel <= '0;
      prevLevel <= '0;
      edgeSticky <= '0;
      expOut <= '0;
      expOe <= '0;
    end
    else
    begin
      syncFirst <= gpioIn;
      syncLevel <= syncFirst;
      prevLevel <= syncLevel;
      if (writeCycle && paddr < cfgLimit)
      begin
        cfgShadow[paddr[$clog2(pinCount)+1:2]] <= pwdata[7:0];
      end
      if (writeCycle && paddr == outputAddr)
      begin
        outShadow <= pwdata;
      end
      // A new edge wins over a clear arriving in the same cycle
      for (int i = 0; i < pinCount; i++)
      begin
        edgeSticky[i] <= cfgShadow[i][3] & edgeKind[i]
                         & (edgeHit[i] | (edgeSticky[i] & ~clearMask[i]));
        expOut[i] <= outShadow[i] & cfgShadow[i][0];
        expOe[i] <= cfgShadow[i][2] & cfgShadow[i][0];
      end
    end
  end

  busResponse: assert property (@(posedge pclk) pready && !pslverr)
    else
    begin
      failCount++;
      $error("mismatch pready/pslverr: got %h/%h expected 1/0",
             $sampled(pready), $sampled(pslverr));
    end

  resetState: assert property (@(posedge pclk)
      $fell(reset) |-> (gpioOut == '0 && gpioOe == '0 && irq == '0 && !irqOr))
    else
    begin
      failCount++;
      $error("mismatch after reset: gpioOut %h gpioOe %h irq %h irqOr %h expected zero",
             $sampled(gpioOut), $sampled(gpioOe), $sampled(irq), $sampled(irqOr));
    end

  readData: assert property (@(posedge pclk) disable iff (reset)
      (psel && penable && !pwrite) |-> prdata == expRead)
    else
    begin
      failCount++;
      $error("mismatch prdata at %h: got %h expected %h",
             $sampled(paddr), $sampled(prdata), $sampled(expRead));
    end

  pinDrive: assert property (@(posedge pclk) disable iff (reset)
      gpioOut == expOut && gpioOe == expOe)
    else
    begin
      failCount++;
      $error("mismatch gpioOut/gpioOe: got %h/%h expected %h/%h",
             $sampled(gpioOut), $sampled(gpioOe), $sampled(expOut), $sampled(expOe));
    end

  irqVector: assert property (@(posedge pclk) disable iff (reset) irq == expIrq)
    else
    begin
      failCount++;
      $error("mismatch irq: got %h expected %h", $sampled(irq), $sampled(expIrq));
    end

  irqSummary: assert property (@(posedge pclk) irqOr == |expIrq)
    else
    begin
      failCount++;
      $error("mismatch irqOr: got %h expected %h", $sampled(irqOr), $sampled(|expIrq));
    end

endmodule

// File: verilog/gpioTop.sv
`timescale 1ns/100ps

module gpioTop (
  input  logic                                 pclk,
  input  logic                                 reset,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [apbMapPkg::addrWidth-1:0]      paddr,
  input  logic [apbMapPkg::dataWidth-1:0]      pwdata,
  input  logic [gpioCfgPkg::pinCount-1:0]      gpioIn,
  output logic [apbMapPkg::dataWidth-1:0]      prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  output logic [gpioCfgPkg::pinCount-1:0]      gpioOut,
  output logic [gpioCfgPkg::pinCount-1:0]      gpioOe,
  output logic [gpioCfgPkg::pinCount-1:0]      irq,
  output logic                                 irqOr
);

  logic [gpioCfgPkg::pinCount-1:0] irqEnable;
  logic [3*gpioCfgPkg::pinCount-1:0] irqTypes;
  logic [gpioCfgPkg::pinCount-1:0] irqClear;
  logic [gpioCfgPkg::pinCount-1:0] pinLevel;

  // Bus registers and pin output drive
  gpioRegBlock i_regBlock (
    .pclk      (pclk),
    .reset     (reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pinLevel  (pinLevel),
    .irqFlags  (irq),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .gpioOut   (gpioOut),
    .gpioOe    (gpioOe),
    .irqEnable (irqEnable),
    .irqTypes  (irqTypes),
    .irqClear  (irqClear)
  );

  // Input synchroniser and interrupt flags
  gpioIrqUnit i_irqUnit (
    .pclk      (pclk),
    .reset     (reset),
    .gpioIn    (gpioIn),
    .irqEnable (irqEnable),
    .irqTypes  (irqTypes),
    .irqClear  (irqClear),
    .pinLevel  (pinLevel),
    .irqFlags  (irq),
    .irqOr     (irqOr)
  );

endmodule

// File: verilog/gpioIrqUnit.sv
`timescale 1ns/100ps

module gpioIrqUnit (
  input  logic                                 pclk,
  input  logic                                 reset,
  input  logic [gpioCfgPkg::pinCount-1:0]      gpioIn,
  input  logic [gpioCfgPkg::pinCount-1:0]      irqEnable,
  input  logic [3*gpioCfgPkg::pinCount-1:0]    irqTypes,
  input  logic [gpioCfgPkg::pinCount-1:0]      irqClear,
  output logic [gpioCfgPkg::pinCount-1:0]      pinLevel,
  output logic [gpioCfgPkg::pinCount-1:0]      irqFlags,
  output logic                                 irqOr
);
  import gpioCfgPkg::*;

  logic [pinCount-1:0] syncStage;
  logic [pinCount-1:0] prevLevel;
  logic [pinCount-1:0] edgeFlags;
  logic [pinCount-1:0] edgeSet;
  logic [pinCount-1:0] isEdgeType;
  logic [pinCount-1:0] levelHit;
  logic [pinCount-1:0] riseSeen;
  logic [pinCount-1:0] fallSeen;

  // Two flops bring the pins into the clock domain and a third keeps the
  // previous level for edge detection
  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      syncStage <= '0;
      pinLevel <= '0;
      prevLevel <= '0;
    end
    else
    begin
      syncStage <= gpioIn;
      pinLevel <= syncStage;
      prevLevel <= pinLevel;
    end
  end

  assign riseSeen = pinLevel & ~prevLevel;
  assign fallSeen = ~pinLevel & prevLevel;

  always_comb
  begin
    for (int i = 0; i < pinCount; i++)
    begin
      edgeSet[i] = 1'b0;
      isEdgeType[i] = 1'b0;
      levelHit[i] = 1'b0;
      case (irqTypes[3*i +: 3])
        irqLevelHigh: levelHit[i] = pinLevel[i];
        irqLevelLow:  levelHit[i] = ~pinLevel[i];
        irqRising:
        begin
          isEdgeType[i] = 1'b1;
          edgeSet[i] = riseSeen[i];
        end
        irqFalling:
        begin
          isEdgeType[i] = 1'b1;
          edgeSet[i] = fallSeen[i];
        end
        irqBothEdges:
        begin
          isEdgeType[i] = 1'b1;
          edgeSet[i] = riseSeen[i] | fallSeen[i];
        end
        default: levelHit[i] = 1'b0;
      endcase
    end
  end

  // Sticky edge flags where a new edge beats a clear in the same cycle
  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      edgeFlags <= '0;
    end
    else
    begin
      edgeFlags <= (edgeSet | (edgeFlags & ~irqClear)) & isEdgeType & irqEnable;
    end
  end

  assign irqFlags = irqEnable & ((isEdgeType & edgeFlags) | (~isEdgeType & levelHit));
  assign irqOr = |irqFlags;

endmodule

// File: verilog/gpioRegBlock.sv
`timescale 1ns/100ps

module gpioRegBlock (
  input  logic                                 pclk,
  input  logic                                 reset,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [apbMapPkg::addrWidth-1:0]      paddr,
  input  logic [apbMapPkg::dataWidth-1:0]      pwdata,
  input  logic [gpioCfgPkg::pinCount-1:0]      pinLevel,
  input  logic [gpioCfgPkg::pinCount-1:0]      irqFlags,
  output logic [apbMapPkg::dataWidth-1:0]      prdata,
  output logic                                 pready,
  output logic                                 pslverr,
  output logic [gpioCfgPkg::pinCount-1:0]      gpioOut,
  output logic [gpioCfgPkg::pinCount-1:0]      gpioOe,
  output logic [gpioCfgPkg::pinCount-1:0]      irqEnable,
  output logic [3*gpioCfgPkg::pinCount-1:0]    irqTypes,
  output logic [gpioCfgPkg::pinCount-1:0]      irqClear
);
  import gpioCfgPkg::*;
  import apbMapPkg::*;

  pinCfgT cfgRegs [pinCount];
  logic [pinCount-1:0] outReg;
  logic [pinCount-1:0] outEnableVec;
  logic [pinCount-1:0] inEnableVec;
  logic [pinCount-1:0] driveEnableVec;
  logic [$clog2(pinCount)-1:0] cfgIndex;
  logic busWrite;
  logic cfgWrite;
  logic statusWrite;
  logic outputWrite;

  // Transfers never stall and never fail
  assign pready = 1'b1;
  assign pslverr = 1'b0;

  // A write lands in the enable phase of the transfer
  assign busWrite = psel & penable & pwrite;
  assign cfgIndex = paddr[$clog2(pinCount)+1:2];
  assign cfgWrite = busWrite && (paddr < cfgLimit);
  assign statusWrite = busWrite && (paddr == irqStatusAddr);
  assign outputWrite = busWrite && (paddr == outputAddr);

  // Ones written to the status word clear the matching edge flags
  assign irqClear = statusWrite ? pwdata : '0;

  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      for (int i = 0; i < pinCount; i++)
      begin
        cfgRegs[i] <= '0;
      end
    end
    else if (cfgWrite)
    begin
      cfgRegs[cfgIndex].raw <= pwdata[7:0];
    end
  end

  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      outReg <= '0;
    end
    else if (outputWrite)
    begin
      outReg <= pwdata;
    end
  end

  // Spread the per-pin fields out into vectors for the pin logic
  always_comb
  begin
    for (int i = 0; i < pinCount; i++)
    begin
      outEnableVec[i] = cfgRegs[i].field.outEnable;
      inEnableVec[i] = cfgRegs[i].field.inEnable;
      driveEnableVec[i] = cfgRegs[i].field.outDriveEnable;
      irqEnable[i] = cfgRegs[i].field.irqEnable;
      irqTypes[3*i +: 3] = cfgRegs[i].field.irqType;
    end
  end

  // Pin outputs follow the registers one clock later
  always_ff @(posedge pclk)
  begin
    if (reset)
    begin
      gpioOut <= '0;
      gpioOe <= '0;
    end
    else
    begin
      gpioOut <= outReg & outEnableVec;
      gpioOe <= driveEnableVec & outEnableVec;
    end
  end

  // Read data is combinational from the address while selected
  always_comb
  begin
    prdata = '0;
    if (psel)
    begin
      if (paddr < cfgLimit)
      begin
        prdata = dataWidth'(cfgRegs[cfgIndex].raw);
      end
      else
      begin
        case (paddr)
          irqStatusAddr: prdata = irqFlags;
          inputAddr:     prdata = pinLevel & inEnableVec;
          outputAddr:    prdata = outReg;
          default:       prdata = '0;
        endcase
      end
    end
  end

endmodule

// File: verilog/apbMapPkg.sv
package apbMapPkg;

  // Peripheral bus widths
  localparam int dataWidth = 32;
  localparam int addrWidth = 8;

  // Addresses below cfgLimit select a configuration byte by word index
  localparam logic [addrWidth-1:0] cfgLimit = 8'h80;

  // Interrupt status word where written ones clear the edge flags
  localparam logic [addrWidth-1:0] irqStatusAddr = 8'h80;

  // Synchronised pin levels as a read-only word
  localparam logic [addrWidth-1:0] inputAddr = 8'h90;

  // Output data register
  localparam logic [addrWidth-1:0] outputAddr = 8'hA0;

endpackage

// File: verilog/gpioCfgPkg.sv
package gpioCfgPkg;

  // Number of GPIO pins served by one block
  localparam int pinCount = 32;

  // One configuration byte per pin. The bus moves it as raw bits, and
  // the pin logic reads the named fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [2:0] irqType;
      logic       spare;
      logic       irqEnable;
      logic       outDriveEnable;
      logic       inEnable;
      logic       outEnable;
    } field;
  } pinCfgT;

  // Interrupt type codes held in the irqType field
  localparam logic [2:0] irqLevelHigh = 3'd0;
  localparam logic [2:0] irqLevelLow = 3'd1;
  localparam logic [2:0] irqRising = 3'd2;
  localparam logic [2:0] irqFalling = 3'd3;
  localparam logic [2:0] irqBothEdges = 3'd4;

  // Codes 5 to 7 are unassigned and never raise an interrupt

endpackage
